/* clear_scanner.sv */
//##############################
// screen clear counters
//##############################
`timescale 1ns/1ns
`default_nettype none

module clear_scanner
	import raster_pkg::*;
#(
	parameter int h_res = 640,
	parameter int v_res = 480
) (
	input  wire      clk,
	input  wire      rst,
	input  wire      clr_coords,
	input  wire      step_coords,
	output coord_x_t scan_x,
	output coord_y_t scan_y,
	output logic     last_px
);

	logic row_end;
	logic col_end;

	// end of a row and bottom row of the screen
	assign row_end = (scan_x == coord_x_t'(h_res - 1));
	assign col_end = (scan_y == coord_y_t'(v_res - 1));
	assign last_px = row_end && col_end;

	// raster order sweep, x fastest
	always_ff @(posedge clk) begin
		if (!rst) begin
			scan_x <= '0;
			scan_y <= '0;
		end else if (clr_coords) begin
			scan_x <= '0;
			scan_y <= '0;
		end else if (step_coords) begin
			if (row_end) begin
				scan_x <= '0;
				// bottom right pixel wraps back to the origin
				scan_y <= col_end ? '0 : scan_y + 1'b1;
			end else begin
				scan_x <= scan_x + 1'b1;
			end
		end
	end

	// column counter must wrap before leaving the screen
	a_x_in_range: assert property (@(posedge clk) disable iff (!rst)
		scan_x < coord_x_t'(h_res));

endmodule

`default_nettype wire

/* flist.f */
raster_pkg.sv
line_fifo.sv
clear_scanner.sv
point_gen.sv
line_generator.sv
raster_top.sv
tb_raster.sv

/* line_fifo.sv */
//##############################
// line record queue
//##############################
`timescale 1ns/1ns
`default_nettype none

module line_fifo
	import raster_pkg::*;
#(
	parameter int fifo_depth = 16
) (
	input  wire       clk,
	input  wire       rst,
	input  wire       wr_en,
	input  line_rec_t wr_data,
	input  wire       rd_en,
	output line_rec_t rd_data,
	output logic      empty,
	output logic      full
);

	localparam int ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
	localparam int cnt_w = $clog2(fifo_depth + 1);

	// record storage, no reset needed on the payload
	line_rec_t mem [fifo_depth];

	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [cnt_w-1:0] count;
	logic             do_wr;
	logic             do_rd;

	// guard against misuse so pointers never slip
	assign do_wr = wr_en && !full;
	assign do_rd = rd_en && !empty;

	assign empty = (count == '0);
	assign full  = (count == cnt_w'(fifo_depth));

	// oldest record is always on the output
	assign rd_data = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= wr_data;
		end
	end

	// pointers wrap explicitly so any depth works
	always_ff @(posedge clk) begin
		if (!rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= (wr_ptr == ptr_w'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= (rd_ptr == ptr_w'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
			end
			// occupancy tracks the net change
			if (do_wr && !do_rd) begin
				count <= count + 1'b1;
			end else if (do_rd && !do_wr) begin
				count <= count - 1'b1;
			end
		end
	end

	// the clipper must respect line_full
	a_no_wr_full: assert property (@(posedge clk) disable iff (!rst) wr_en |-> !full);
	// the generator only pops a presented record
	a_no_rd_empty: assert property (@(posedge clk) disable iff (!rst) rd_en |-> !empty);

endmodule

`default_nettype wire

/* line_generator.sv */
//##############################
// clear and line drawing FSM
//##############################
`timescale 1ns/1ns
`default_nettype none

module line_generator
	import raster_pkg::*;
(
	input  wire       clk,
	input  wire       rst,
	// line queue
	input  line_rec_t fifo_data,
	input  wire       fifo_empty,
	output logic      fifo_rd_en,
	// clipper, object and matrix levels
	input  wire       end_of_objects,
	input  wire       frame_start,
	input  wire       obj_change,
	input  color_t    bk_color,
	// clear scanner
	output logic      clr_coords,
	output logic      step_coords,
	input  coord_x_t  scan_x,
	input  coord_y_t  scan_y,
	input  wire       last_px,
	// step unit
	output coord_t    x_off,
	output coord_t    y_off,
	output delta_t    dx,
	output delta_t    dy,
	input  coord_t    x_next,
	input  coord_t    y_next,
	// frame buffer
	input  wire       frame_ready,
	output logic      px_draw,
	output coord_x_t  px_x,
	output coord_y_t  px_y,
	output color_t    px_color,
	output octant_t   octant,
	output logic      raster_done
);

	gen_state_t state;
	gen_state_t nxt_state;

	// record of the line being walked
	line_rec_t cap_rec;

	coord_x_t cap_x_init;
	coord_x_t cap_x_final;
	coord_t   cap_y_init;
	coord_t   cap_y_final;
	color_t   cap_color;
	logic     fifo_valid;

	coord_x_t cur_x;
	coord_t   cur_y;
	logic     end_pt;
	logic     clr_sel;
	logic     load_next;

	// unpack the captured record
	assign cap_x_init  = cap_rec[rec_x_init_lsb +: coord_w];
	assign cap_y_init  = cap_rec[rec_y_init_lsb +: coord_w];
	assign cap_x_final = cap_rec[rec_x_final_lsb +: coord_w];
	assign cap_y_final = cap_rec[rec_y_final_lsb +: coord_w];
	assign dy          = cap_rec[rec_dy_lsb +: delta_w];
	assign dx          = cap_rec[rec_dx_lsb +: delta_w];
	assign cap_color   = cap_rec[rec_color_lsb +: color_w];
	assign octant      = cap_rec[rec_octant_lsb +: octant_w];

	// valid is taken from the queue head, before capture
	assign fifo_valid = fifo_data[rec_valid_bit];

	// capture on pop
	always_ff @(posedge clk) begin
		if (fifo_rd_en) begin
			cap_rec <= fifo_data;
		end
	end

	// offset from the start point, walked from (0,0)
	always_ff @(posedge clk) begin
		if (!rst) begin
			x_off <= '0;
			y_off <= '0;
		end else if (fifo_rd_en) begin
			x_off <= '0;
			y_off <= '0;
		end else if (load_next) begin
			x_off <= x_next;
			y_off <= y_next;
		end
	end

	// absolute point on screen
	assign cur_x  = cap_x_init + coord_x_t'(x_off);
	assign cur_y  = cap_y_init + y_off;
	assign end_pt = (cur_x == cap_x_final) && (cur_y == cap_y_final);

	// background pixels while clearing, line pixels otherwise
	assign clr_sel  = (state == clr_screen);
	assign px_draw  = (state == clr_screen) || (state == gen_points);
	assign px_x     = clr_sel ? scan_x : cur_x;
	assign px_y     = clr_sel ? scan_y : cur_y[coord_y_w-1:0];
	assign px_color = clr_sel ? bk_color : cap_color;

	always_ff @(posedge clk) begin
		if (!rst) begin
			state <= idle;
		end else begin
			state <= nxt_state;
		end
	end

	always_comb begin
		nxt_state   = state;
		fifo_rd_en  = 1'b0;
		clr_coords  = 1'b0;
		step_coords = 1'b0;
		load_next   = 1'b0;
		raster_done = 1'b0;
		case (state)
			idle: begin
				// new frame with changed objects starts a clear
				if (frame_start && obj_change) begin
					clr_coords = 1'b1;
					nxt_state  = clr_screen;
				end
			end
			clr_screen: begin
				// one pixel per accepted cycle
				if (frame_ready) begin
					step_coords = 1'b1;
					if (last_px) begin
						nxt_state = pop_line;
					end
				end
			end
			pop_line: begin
				if (!fifo_empty) begin
					// invalid records are dropped here
					fifo_rd_en = 1'b1;
					if (fifo_valid) begin
						nxt_state = gen_points;
					end
				end else if (end_of_objects && frame_start) begin
					raster_done = 1'b1;
					// back to back frames skip idle
					if (obj_change) begin
						clr_coords = 1'b1;
						nxt_state  = clr_screen;
					end else begin
						nxt_state = idle;
					end
				end
			end
			gen_points: begin
				if (frame_ready) begin
					if (end_pt) begin
						nxt_state = pop_line;
					end else begin
						load_next = 1'b1;
					end
				end
			end
			default: begin
				nxt_state = idle;
			end
		endcase
	end

	// a stalled pixel stays on the bus untouched until taken
	a_hold_stall: assert property (@(posedge clk) disable iff (!rst)
		(px_draw && !frame_ready) |=>
		(px_draw && $stable(px_x) && $stable(px_y) && $stable(px_color)));

endmodule

`default_nettype wire

/* point_gen.sv */
//##############################
// line step unit
//##############################
`timescale 1ns/1ns
`default_nettype none

module point_gen
	import raster_pkg::*;
(
	input  coord_t x_off,
	input  coord_t y_off,
	input  delta_t dx,
	input  delta_t dy,
	output coord_t x_next,
	output coord_t y_next
);

	// wide enough for an 11 by 11 bit signed product plus margin
	localparam int prod_w = 2 * delta_w + 2;

	logic signed [prod_w-1:0] x_step;
	logic signed [prod_w-1:0] prod_xdy;
	logic signed [prod_w-1:0] prod_ydx;
	logic signed [prod_w-1:0] err_stay;
	logic signed [prod_w-1:0] err_abs;
	logic signed [prod_w-1:0] twice_err;
	logic signed [prod_w-1:0] dx_ext;
	logic                     do_move;

	// x always moves one column right
	assign x_step = prod_w'(x_off) + prod_w'(1);
	assign x_next = x_off + coord_t'(1);

	// error of staying on the current row, scaled by dx
	assign prod_xdy = x_step * prod_w'(dy);
	assign prod_ydx = prod_w'(y_off) * prod_w'(dx);
	assign err_stay = prod_xdy - prod_ydx;

	// magnitude only, the direction comes from dy
	assign err_abs   = err_stay[prod_w-1] ? -err_stay : err_stay;
	assign twice_err = err_abs <<< 1;
	assign dx_ext    = prod_w'(dx);

	// more than half a row off means take the diagonal step
	assign do_move = (twice_err > dx_ext);

	always_comb begin
		y_next = y_off;
		if (do_move) begin
			// negative dy walks up the screen
			y_next = dy[delta_w-1] ? y_off - coord_t'(1) : y_off + coord_t'(1);
		end
	end

endmodule

`default_nettype wire

/* raster_pkg.sv */
//##############################
// rasterizer shared types
//##############################
`default_nettype none

package raster_pkg;

	// field widths of a line record
	localparam int coord_w   = 10;
	localparam int coord_y_w = 9;
	localparam int delta_w   = 11;
	localparam int color_w   = 3;
	localparam int octant_w  = 3;

	// record fields, packed from the low end upward
	localparam int rec_octant_lsb  = 0;
	localparam int rec_valid_bit   = rec_octant_lsb + octant_w;
	localparam int rec_color_lsb   = rec_valid_bit + 1;
	localparam int rec_dx_lsb      = rec_color_lsb + color_w;
	localparam int rec_dy_lsb      = rec_dx_lsb + delta_w;
	localparam int rec_y_final_lsb = rec_dy_lsb + delta_w;
	localparam int rec_x_final_lsb = rec_y_final_lsb + coord_w;
	localparam int rec_y_init_lsb  = rec_x_final_lsb + coord_w;
	localparam int rec_x_init_lsb  = rec_y_init_lsb + coord_w;
	localparam int rec_width       = rec_x_init_lsb + coord_w;

	// screen column and row as seen by the frame buffer
	typedef logic [coord_w-1:0] coord_x_t;
	typedef logic [coord_y_w-1:0] coord_y_t;
	// signed coordinate or offset inside a line walk
	typedef logic signed [coord_w-1:0] coord_t;
	typedef logic signed [delta_w-1:0] delta_t;
	typedef logic [color_w-1:0] color_t;
	typedef logic [octant_w-1:0] octant_t;
	typedef logic [rec_width-1:0] line_rec_t;

	// line generator states
	typedef enum logic [1:0] {
		idle,
		clr_screen,
		pop_line,
		gen_points
	} gen_state_t;

endpackage

`default_nettype wire

/* raster_top.sv */
//##############################
// line rasterizer top
//##############################
`timescale 1ns/1ns
`default_nettype none

module raster_top
	import raster_pkg::*;
#(
	parameter int h_res      = 640,
	parameter int v_res      = 480,
	parameter int fifo_depth = 16
) (
	input  wire       clk,
	input  wire       rst,
	// clipper write port
	input  wire       line_wr_en,
	input  line_rec_t line_wr_data,
	output logic      line_full,
	// frame and object levels
	input  wire       end_of_objects,
	input  wire       frame_start,
	input  wire       obj_change,
	input  color_t    bk_color,
	// frame buffer
	input  wire       frame_ready,
	output logic      px_draw,
	output coord_x_t  px_x,
	output coord_y_t  px_y,
	output color_t    px_color,
	output octant_t   octant,
	output logic      raster_done
);

	line_rec_t fifo_data;
	logic      fifo_empty;
	logic      fifo_rd_en;
	logic      clr_coords;
	logic      step_coords;
	coord_x_t  scan_x;
	coord_y_t  scan_y;
	logic      last_px;
	coord_t    x_off;
	coord_t    y_off;
	coord_t    x_next;
	coord_t    y_next;
	delta_t    dx;
	delta_t    dy;

	line_fifo #(
		.fifo_depth (fifo_depth)
	) i_fifo (
		.clk     (clk),
		.rst     (rst),
		.wr_en   (line_wr_en),
		.wr_data (line_wr_data),
		.rd_en   (fifo_rd_en),
		.rd_data (fifo_data),
		.empty   (fifo_empty),
		.full    (line_full)
	);

	clear_scanner #(
		.h_res (h_res),
		.v_res (v_res)
	) i_scanner (
		.clk         (clk),
		.rst         (rst),
		.clr_coords  (clr_coords),
		.step_coords (step_coords),
		.scan_x      (scan_x),
		.scan_y      (scan_y),
		.last_px     (last_px)
	);

	// stateless, so it sits beside the generator
	point_gen i_point_gen (
		.x_off  (x_off),
		.y_off  (y_off),
		.dx     (dx),
		.dy     (dy),
		.x_next (x_next),
		.y_next (y_next)
	);

	line_generator i_gen (
		.clk            (clk),
		.rst            (rst),
		.fifo_data      (fifo_data),
		.fifo_empty     (fifo_empty),
		.fifo_rd_en     (fifo_rd_en),
		.end_of_objects (end_of_objects),
		.frame_start    (frame_start),
		.obj_change     (obj_change),
		.bk_color       (bk_color),
		.clr_coords     (clr_coords),
		.step_coords    (step_coords),
		.scan_x         (scan_x),
		.scan_y         (scan_y),
		.last_px        (last_px),
		.x_off          (x_off),
		.y_off          (y_off),
		.dx             (dx),
		.dy             (dy),
		.x_next         (x_next),
		.y_next         (y_next),
		.frame_ready    (frame_ready),
		.px_draw        (px_draw),
		.px_x           (px_x),
		.px_y           (px_y),
		.px_color       (px_color),
		.octant         (octant),
		.raster_done    (raster_done)
	);

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build and run the rasterizer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f flist.f --top-module tb_raster -o sim_raster

out=$(./obj_dir/sim_raster)
echo "$out"

if echo "$out" | grep -q "^TB PASSED$"; then
	exit 0
else
	exit 1
fi

/* tb_raster.sv */
//##############################
// rasterizer testbench
//##############################
`timescale 1ns/1ns
`default_nettype none

module tb_raster
	import raster_pkg::*;
();

	// small screen keeps the clear short
	localparam int h_res = 16;
	localparam int v_res = 12;
	localparam int fifo_depth = 16;
	localparam int wait_limit = 4000;
	localparam color_t bg_color = 3'd5;

	// wait conditions
	localparam int w_draw = 0;
	localparam int w_drained = 1;
	localparam int w_done = 2;

	logic      clk;
	logic      rst;
	logic      line_wr_en;
	line_rec_t line_wr_data;
	logic      line_full;
	logic      end_of_objects;
	logic      frame_start;
	logic      obj_change;
	color_t    bk_color;
	logic      frame_ready;
	logic      px_draw;
	coord_x_t  px_x;
	coord_y_t  px_y;
	color_t    px_color;
	octant_t   octant;
	logic      raster_done;

	// expected pixel as octant check flag, x, y, colour, octant
	logic [25:0] exp_q [$];
	logic [25:0] exp_px;
	logic [31:0] lfsr;
	logic        rnd_ready;
	// frame buffer refuses every pixel while set
	logic        hold_ready;
	logic        hung;
	string       cur_test;
	int          err_cnt;
	int          test_err0;
	int          test_cnt;
	int          fail_cnt;
	// last stalled pixel, for the hold check
	logic        held_valid;
	coord_x_t    held_x;
	coord_y_t    held_y;
	color_t      held_color;
	gen_state_t  seen_state;
	line_rec_t   recs [8];

	raster_top #(
		.h_res      (h_res),
		.v_res      (v_res),
		.fifo_depth (fifo_depth)
	) i_dut (
		.clk            (clk),
		.rst            (rst),
		.line_wr_en     (line_wr_en),
		.line_wr_data   (line_wr_data),
		.line_full      (line_full),
		.end_of_objects (end_of_objects),
		.frame_start    (frame_start),
		.obj_change     (obj_change),
		.bk_color       (bk_color),
		.frame_ready    (frame_ready),
		.px_draw        (px_draw),
		.px_x           (px_x),
		.px_y           (px_y),
		.px_color       (px_color),
		.octant         (octant),
		.raster_done    (raster_done)
	);

	always #5 clk = ~clk;

	// galois lfsr, stepped once per bit taken
	function automatic int unsigned rand_bits(input int n);
		int unsigned r;
		int i;
		r = 0;
		for (i = 0; i < n; i++) begin
			r = (r << 1) | lfsr[0];
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hD0000001) : (lfsr >> 1);
		end
		return r;
	endfunction

	function automatic logic [25:0] pack_px(input bit chk_oct, input int x, input int y,
		input color_t color, input octant_t oct);
		return {chk_oct, 10'(x), 9'(y), color, oct};
	endfunction

	// walk a line by the step rule and queue every pixel it covers
	function automatic void expect_line(input int x0, input int y0, input int dx,
		input int dy, input color_t color, input octant_t oct);
		int xo;
		int yo;
		int err;
		xo = 0;
		yo = 0;
		while (xo <= dx) begin
			exp_q.push_back(pack_px(1'b1, x0 + xo, y0 + yo, color, oct));
			// error of staying on this row, scaled by dx
			err = (xo + 1) * dy - yo * dx;
			if (err < 0) begin
				err = -err;
			end
			if (2 * err > dx) begin
				yo = yo + ((dy < 0) ? -1 : 1);
			end
			xo++;
		end
	endfunction

	// canonical line kept on screen, expected pixels queued when valid
	function automatic line_rec_t random_line(input bit valid);
		int dx;
		int mag;
		int dy;
		int x0;
		int y0;
		int lo;
		int hi;
		color_t color;
		octant_t oct;
		line_rec_t rec;
		dx = rand_bits(4) % 10;
		mag = rand_bits(4) % (dx + 1);
		dy = (rand_bits(1) != 0) ? -mag : mag;
		lo = (dy < 0) ? -dy : 0;
		hi = (dy > 0) ? v_res - 1 - dy : v_res - 1;
		y0 = lo + rand_bits(4) % (hi - lo + 1);
		x0 = rand_bits(4) % (h_res - dx);
		color = color_t'(rand_bits(3));
		oct = octant_t'(rand_bits(3));
		rec = '0;
		rec[rec_x_init_lsb +: coord_w] = coord_w'(x0);
		rec[rec_y_init_lsb +: coord_w] = coord_w'(y0);
		rec[rec_x_final_lsb +: coord_w] = coord_w'(x0 + dx);
		rec[rec_y_final_lsb +: coord_w] = coord_w'(y0 + dy);
		rec[rec_dy_lsb +: delta_w] = delta_w'(dy);
		rec[rec_dx_lsb +: delta_w] = delta_w'(dx);
		rec[rec_color_lsb +: color_w] = color;
		rec[rec_valid_bit] = valid;
		rec[rec_octant_lsb +: octant_w] = oct;
		if (valid) begin
			expect_line(x0, y0, dx, dy, color, oct);
		end
		return rec;
	endfunction

	function automatic bit cond_met(input int what);
		case (what)
			w_draw: return px_draw;
			w_drained: return exp_q.size() == 0;
			default: return raster_done;
		endcase
	endfunction

	// polls on the falling edge, flags a hang after wait_limit cycles
	task automatic wait_until(input int what, input string desc);
		int n;
		n = 0;
		if (hung) begin
			return;
		end
		@(negedge clk);
		while (!cond_met(what)) begin
			if (n == wait_limit) begin
				$display("timeout: %s waited %0d cycles for %s", cur_test, n, desc);
				hung = 1'b1;
				return;
			end
			n++;
			@(negedge clk);
		end
	endtask

	task automatic write_line(input line_rec_t rec);
		@(posedge clk);
		line_wr_en   <= 1'b1;
		line_wr_data <= rec;
		@(posedge clk);
		line_wr_en   <= 1'b0;
	endtask

	task automatic queue_clear();
		int x;
		int y;
		for (y = 0; y < v_res; y++) begin
			for (x = 0; x < h_res; x++) begin
				exp_q.push_back(pack_px(1'b0, x, y, bg_color, octant_t'(0)));
			end
		end
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		test_err0 = err_cnt;
	endtask

	task automatic end_test();
		test_cnt++;
		if (err_cnt == test_err0 && !hung) begin
			$display("test %s: ok", cur_test);
		end else begin
			fail_cnt++;
			$display("test %s: failed with %0d errors", cur_test, err_cnt - test_err0);
		end
	endtask

	task automatic clear_frame();
		start_test("clear");
		queue_clear();
		@(posedge clk);
		frame_start <= 1'b1;
		obj_change  <= 1'b1;
		wait_until(w_draw, "px_draw");
		@(posedge clk);
		frame_start <= 1'b0;
		obj_change  <= 1'b0;
		wait_until(w_drained, "all clear pixels");
		end_test();
	endtask

	// mixed queues put invalid records on even slots
	task automatic draw_lines(input string name, input int n, input bit mix_invalid,
		input bit stall);
		int i;
		bit valid;
		start_test(name);
		// draw all records first so the lfsr order is fixed
		for (i = 0; i < n; i++) begin
			valid = !mix_invalid || (i % 2 == 1);
			recs[i] = random_line(valid);
		end
		rnd_ready = stall;
		for (i = 0; i < n; i++) begin
			write_line(recs[i]);
		end
		wait_until(w_drained, "all line pixels");
		rnd_ready = 1'b0;
		end_test();
	endtask

	// a line stalled on its first pixel stops the pops, so the queue fills up
	task automatic fill_queue();
		int i;
		start_test("full");
		hold_ready = 1'b1;
		write_line(random_line(1'b1));
		wait_until(w_draw, "stalled line pixel");
		for (i = 0; i < fifo_depth; i++) begin
			if (!hung) begin
				write_line('0);
				@(negedge clk);
				// full only once every slot holds a record
				if (line_full != (i == fifo_depth - 1)) begin
					$display("[FAIL] %s line_full after %0d writes expected %0d actual %0d",
						cur_test, i + 1, i == fifo_depth - 1, line_full);
					err_cnt++;
				end
			end
		end
		hold_ready = 1'b0;
		wait_until(w_drained, "stalled line pixels");
		end_test();
	endtask

	task automatic finish_frame();
		int dones;
		int draws;
		dones = 0;
		draws = 0;
		start_test("completion");
		@(posedge clk);
		end_of_objects <= 1'b1;
		frame_start    <= 1'b1;
		obj_change     <= 1'b0;
		wait_until(w_done, "raster_done");
		// levels stay high, generator must rest in idle
		repeat (20) begin
			@(negedge clk);
			if (raster_done) begin
				dones++;
			end
			if (px_draw) begin
				draws++;
			end
		end
		if (dones != 0) begin
			$display("[FAIL] %s extra raster_done expected 0 actual %0d", cur_test, dones);
			err_cnt++;
		end
		if (draws != 0) begin
			$display("[FAIL] %s pixels in idle expected 0 actual %0d", cur_test, draws);
			err_cnt++;
		end
		seen_state = i_dut.i_gen.state;
		if (seen_state != idle) begin
			$display("[FAIL] %s state expected idle actual %s", cur_test, seen_state.name());
			err_cnt++;
		end
		end_test();
	endtask

	task automatic chain_frames();
		start_test("back_to_back");
		queue_clear();
		queue_clear();
		@(posedge clk);
		obj_change <= 1'b1;
		wait_until(w_done, "first raster_done");
		@(posedge clk);
		obj_change <= 1'b0;
		// next clear starts at once, no stop in idle
		@(negedge clk);
		if (!hung && !px_draw) begin
			$display("[FAIL] %s px_draw after done expected 1 actual 0", cur_test);
			err_cnt++;
		end
		wait_until(w_done, "second raster_done");
		if (exp_q.size() != 0) begin
			$display("[FAIL] %s pixels left expected 0 actual %0d", cur_test, exp_q.size());
			err_cnt++;
		end
		@(posedge clk);
		end_of_objects <= 1'b0;
		frame_start    <= 1'b0;
		end_test();
	endtask

	// frame buffer acceptance level
	initial begin
		frame_ready = 1'b1;
		forever begin
			@(posedge clk);
			frame_ready <= hold_ready ? 1'b0 : (rnd_ready ? (rand_bits(1) != 0) : 1'b1);
		end
	end

	// frame buffer model, compares every taken pixel
	always @(negedge clk) begin
		if (!rst) begin
			held_valid = 1'b0;
		end else begin
			if (held_valid) begin
				if (!px_draw || px_x != held_x || px_y != held_y || px_color != held_color) begin
					$display("[FAIL] %s held pixel expected %0d,%0d c%0d actual %0d,%0d c%0d",
						cur_test, held_x, held_y, held_color, px_x, px_y, px_color);
					err_cnt++;
				end
			end
			held_valid = px_draw && !frame_ready;
			held_x = px_x;
			held_y = px_y;
			held_color = px_color;
			if (px_draw && frame_ready) begin
				if (exp_q.size() == 0) begin
					$display("unexpected pixel at %0d,%0d in %s", px_x, px_y, cur_test);
					err_cnt++;
				end else begin
					exp_px = exp_q.pop_front();
					if (exp_px[24:3] != {px_x, px_y, px_color}
						|| (exp_px[25] && exp_px[2:0] != octant)) begin
						$display("[FAIL] %s pixel expected %0d,%0d c%0d o%0d actual %0d,%0d c%0d o%0d",
							cur_test, exp_px[24:15], exp_px[14:6], exp_px[5:3], exp_px[2:0],
							px_x, px_y, px_color, octant);
						err_cnt++;
					end
				end
			end
		end
	end

	initial begin
		clk = 1'b0;
		rst <= 1'b0;
		line_wr_en <= 1'b0;
		line_wr_data <= '0;
		end_of_objects <= 1'b0;
		frame_start <= 1'b0;
		obj_change <= 1'b0;
		bk_color <= bg_color;
		lfsr = 32'h66852719;
		rnd_ready = 1'b0;
		hold_ready = 1'b0;
		hung = 1'b0;
		err_cnt = 0;
		test_cnt = 0;
		fail_cnt = 0;
		cur_test = "reset";
		repeat (4) @(posedge clk);
		rst <= 1'b1;
		clear_frame();
		draw_lines("lines", 6, 1'b0, 1'b0);
		draw_lines("invalid", 7, 1'b1, 1'b0);
		draw_lines("backpressure", 8, 1'b0, 1'b1);
		fill_queue();
		finish_frame();
		chain_frames();
		$display("tests %0d, failed %0d, errors %0d", test_cnt, fail_cnt, err_cnt);
		if (hung || err_cnt != 0 || fail_cnt != 0) begin
			$display("TB FAILED");
		end else begin
			$display("TB PASSED");
		end
		$finish;
	end

endmodule

`default_nettype wire
